// File: src/mem_params.svh
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// data word
`define MEM_WIDTH 32

// virtual banks, each one 1RW
`define MEM_NUMVBNK 4
`define MEM_BITVBNK 2

// rows per bank, also the stash depth
`define MEM_NUMVROW 16
`define MEM_BITVROW 4

// cycles from a bank read strobe to its data
`define MEM_BANK_DELAY 2

`endif

// File: src/bank_pkg.sv
`include "mem_params.svh"

package bank_pkg;

  typedef logic [`MEM_WIDTH-1:0] word_t;

  typedef logic [`MEM_BITVBNK-1:0] bank_idx_t;

  typedef logic [`MEM_BITVROW-1:0] row_t;

endpackage

// File: src/port_pkg.sv
package port_pkg;

  // owner of the stash word in one row.
  typedef struct packed {
    logic                valid;
    bank_pkg::bank_idx_t bank;
  } map_entry_t;

  // where a logical read gets its data.
  typedef enum logic {
    src_bank,
    src_stash
  } rd_src_e;

endpackage

// File: src/bank_if.sv
`timescale 1ns/1ns

interface bank_if;
  import bank_pkg::*;

  logic  read;
  logic  write;
  row_t  addr;
  word_t din;
  word_t dout; // valid MEM_BANK_DELAY cycles after read.

  modport mux (
    output read,
    output write,
    output addr,
    output din,
    input  dout
  );

  modport bank (
    input  read,
    input  write,
    input  addr,
    input  din,
    output dout
  );
endinterface

// File: src/bank_array.sv
`timescale 1ns/1ns
`include "mem_params.svh"

module bank_array (
  input logic clk,
  input logic rst,
  bank_if.bank bnk
);
  import bank_pkg::*;

  word_t mem_q [`MEM_NUMVROW];
  word_t pipe_q [`MEM_BANK_DELAY];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `MEM_NUMVROW; i++) begin
        mem_q[i] <= '0;
      end
    end else if (bnk.write) begin
      mem_q[bnk.addr] <= bnk.din;
    end
  end

  // first stage samples the row, the rest only delay it.
  always_ff @(posedge clk) begin
    if (bnk.read) begin
      pipe_q[0] <= mem_q[bnk.addr];
    end
    for (int i = 1; i < `MEM_BANK_DELAY; i++) begin
      pipe_q[i] <= pipe_q[i-1];
    end
  end

  assign bnk.dout = pipe_q[`MEM_BANK_DELAY-1];

endmodule

// File: src/bank_mux.sv
`timescale 1ns/1ns
`include "mem_params.svh"

module bank_mux (
  input  logic                clk,
  input  logic                rd,
  input  logic                wr,
  input  logic                ev,
  input  bank_pkg::bank_idx_t rd_bank,
  input  bank_pkg::bank_idx_t wr_bank,
  input  bank_pkg::bank_idx_t ev_bank,
  input  bank_pkg::row_t      rd_row,
  input  bank_pkg::row_t      wr_row,
  input  bank_pkg::row_t      ev_row,
  input  bank_pkg::word_t     wr_data,
  input  bank_pkg::word_t     ev_data,
  bank_if.mux                 banks [`MEM_NUMVBNK],
  output bank_pkg::word_t     bank_dout
);
  import bank_pkg::*;

  logic [`MEM_NUMVBNK-1:0] rd_hit;
  logic [`MEM_NUMVBNK-1:0] wr_hit;
  logic [`MEM_NUMVBNK-1:0] ev_hit;
  word_t                   dout_arr [`MEM_NUMVBNK];
  bank_idx_t               rd_bank_q [`MEM_BANK_DELAY];

  for (genvar b = 0; b < `MEM_NUMVBNK; b++) begin : g_bank
    assign rd_hit[b] = rd && (rd_bank == bank_idx_t'(b));
    assign wr_hit[b] = wr && (wr_bank == bank_idx_t'(b));
    assign ev_hit[b] = ev && (ev_bank == bank_idx_t'(b));

    // the controller never aims two requests at one bank.
    assign banks[b].read  = rd_hit[b];
    assign banks[b].write = wr_hit[b] || ev_hit[b];

    assign banks[b].addr = rd_hit[b] ? rd_row :
                           wr_hit[b] ? wr_row :
                           ev_hit[b] ? ev_row : '0;

    assign banks[b].din = wr_hit[b] ? wr_data :
                          ev_hit[b] ? ev_data : '0;

    assign dout_arr[b] = banks[b].dout;
  end

  // bank index follows the read through the bank latency.
  always_ff @(posedge clk) begin
    rd_bank_q[0] <= rd_bank;
    for (int i = 1; i < `MEM_BANK_DELAY; i++) begin
      rd_bank_q[i] <= rd_bank_q[i-1];
    end
  end

  assign bank_dout = dout_arr[rd_bank_q[`MEM_BANK_DELAY-1]];

endmodule

// File: src/stash_ram.sv
`timescale 1ns/1ns
`include "mem_params.svh"

module stash_ram (
  input  logic                 clk,
  input  logic                 rst,
  input  bank_pkg::row_t       rd_row,
  input  bank_pkg::row_t       wr_row,
  output port_pkg::map_entry_t rd_map,
  output port_pkg::map_entry_t wr_map,
  output bank_pkg::word_t      rd_word,
  output bank_pkg::word_t      wr_word,
  input  logic                 st_we,
  input  bank_pkg::row_t       st_row,
  input  port_pkg::map_entry_t st_map,
  input  bank_pkg::word_t      st_data
);
  import bank_pkg::*;
  import port_pkg::*;

  map_entry_t map_q [`MEM_NUMVROW];
  word_t      word_q [`MEM_NUMVROW];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `MEM_NUMVROW; i++) begin
        map_q[i]  <= '0; // all rows unowned.
        word_q[i] <= '0;
      end
    end else if (st_we) begin
      map_q[st_row]  <= st_map;
      word_q[st_row] <= st_data;
    end
  end

  // read port, looked up at the read address.
  assign rd_map  = map_q[rd_row];
  assign rd_word = word_q[rd_row];

  // eviction lookup at the write address.
  assign wr_map  = map_q[wr_row];
  assign wr_word = word_q[wr_row];

endmodule

// File: src/stash_ctrl.sv
`timescale 1ns/1ns
`include "mem_params.svh"

module stash_ctrl (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 rd,
  input  logic                 wr,
  input  bank_pkg::bank_idx_t  rd_bank,
  input  bank_pkg::bank_idx_t  wr_bank,
  input  bank_pkg::row_t       rd_row,
  input  bank_pkg::row_t       wr_row,
  input  bank_pkg::word_t      wr_data,
  input  port_pkg::map_entry_t rd_map,
  input  port_pkg::map_entry_t wr_map,
  input  bank_pkg::word_t      rd_word,
  input  bank_pkg::word_t      wr_word,
  output logic                 st_we,
  output bank_pkg::row_t       st_row,
  output port_pkg::map_entry_t st_map,
  output bank_pkg::word_t      st_data,
  output logic                 mux_rd,
  output logic                 mux_wr,
  output logic                 mux_ev,
  output bank_pkg::bank_idx_t  mux_rd_bank,
  output bank_pkg::bank_idx_t  mux_wr_bank,
  output bank_pkg::bank_idx_t  mux_ev_bank,
  output bank_pkg::row_t       mux_rd_row,
  output bank_pkg::row_t       mux_wr_row,
  output bank_pkg::row_t       mux_ev_row,
  output bank_pkg::word_t      mux_wr_data,
  output bank_pkg::word_t      mux_ev_data,
  input  bank_pkg::word_t      bank_dout,
  output bank_pkg::word_t      rdata,
  output logic                 rvalid
);
  import bank_pkg::*;
  import port_pkg::*;

  logic                      conflict;
  logic                      from_stash;
  rd_src_e                   src_next;
  logic [`MEM_BANK_DELAY-1:0] rd_q;
  rd_src_e                   src_q [`MEM_BANK_DELAY];
  word_t                     word_q [`MEM_BANK_DELAY];

  assign conflict   = rd && wr && (rd_bank == wr_bank); // bank busy with the read.
  assign from_stash = rd_map.valid && (rd_map.bank == rd_bank);
  assign src_next   = from_stash ? src_stash : src_bank;

  // the bank is read even when the stash serves the data.
  assign mux_rd      = rd;
  assign mux_rd_bank = rd_bank;
  assign mux_rd_row  = rd_row;

  assign mux_wr      = wr && !conflict;
  assign mux_wr_bank = wr_bank;
  assign mux_wr_row  = wr_row;
  assign mux_wr_data = wr_data;

  // displaced stash word goes home; that bank is neither read nor written.
  assign mux_ev      = conflict && wr_map.valid && (wr_map.bank != wr_bank);
  assign mux_ev_bank = wr_map.bank;
  assign mux_ev_row  = wr_row;
  assign mux_ev_data = wr_word;

  always_comb begin
    st_we   = 1'b0;
    st_row  = wr_row;
    st_map  = wr_map;
    st_data = wr_word;
    if (conflict) begin
      st_we   = 1'b1;
      st_map  = '{valid: 1'b1, bank: wr_bank};
      st_data = wr_data;
    end else if (wr && wr_map.valid && (wr_map.bank == wr_bank)) begin
      st_we  = 1'b1; // stale copy, bank now holds the word.
      st_map = '{valid: 1'b0, bank: wr_bank};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_q <= '0;
      for (int i = 0; i < `MEM_BANK_DELAY; i++) begin
        src_q[i] <= src_bank;
      end
    end else begin
      rd_q[0]  <= rd;
      src_q[0] <= src_next;
      for (int i = 1; i < `MEM_BANK_DELAY; i++) begin
        rd_q[i]  <= rd_q[i-1];
        src_q[i] <= src_q[i-1];
      end
    end
  end

  // stash word is taken in the read cycle, before any stash update lands.
  always_ff @(posedge clk) begin
    word_q[0] <= rd_word;
    for (int i = 1; i < `MEM_BANK_DELAY; i++) begin
      word_q[i] <= word_q[i-1];
    end
  end

  assign rdata  = (src_q[`MEM_BANK_DELAY-1] == src_stash) ? word_q[`MEM_BANK_DELAY-1]
                                                           : bank_dout;
  assign rvalid = rd_q[`MEM_BANK_DELAY-1];

endmodule

// File: src/mrw_mem_top.sv
`timescale 1ns/1ns
`include "mem_params.svh"

module mrw_mem_top (
  input  logic                clk,
  input  logic                rst,
  input  logic                rd,
  input  logic                wr,
  input  bank_pkg::bank_idx_t rd_bank,
  input  bank_pkg::bank_idx_t wr_bank,
  input  bank_pkg::row_t      rd_row,
  input  bank_pkg::row_t      wr_row,
  input  bank_pkg::word_t     wr_data,
  output bank_pkg::word_t     rdata,
  output logic                rvalid
);
  import bank_pkg::*;
  import port_pkg::*;

  map_entry_t rd_map;
  map_entry_t wr_map;
  word_t      rd_word;
  word_t      wr_word;
  logic       st_we;
  row_t       st_row;
  map_entry_t st_map;
  word_t      st_data;
  logic       mux_rd;
  logic       mux_wr;
  logic       mux_ev;
  bank_idx_t  mux_rd_bank;
  bank_idx_t  mux_wr_bank;
  bank_idx_t  mux_ev_bank;
  row_t       mux_rd_row;
  row_t       mux_wr_row;
  row_t       mux_ev_row;
  word_t      mux_wr_data;
  word_t      mux_ev_data;
  word_t      bank_dout;

  bank_if banks [`MEM_NUMVBNK] ();

  stash_ctrl i_stash_ctrl (
    .clk, .rst, .rd, .wr, .rd_bank, .wr_bank, .rd_row, .wr_row, .wr_data,
    .rd_map, .wr_map, .rd_word, .wr_word,
    .st_we, .st_row, .st_map, .st_data,
    .mux_rd, .mux_wr, .mux_ev, .mux_rd_bank, .mux_wr_bank, .mux_ev_bank,
    .mux_rd_row, .mux_wr_row, .mux_ev_row, .mux_wr_data, .mux_ev_data,
    .bank_dout, .rdata, .rvalid
  );

  stash_ram i_stash_ram (
    .clk, .rst, .rd_row, .wr_row, .rd_map, .wr_map, .rd_word, .wr_word,
    .st_we, .st_row, .st_map, .st_data
  );

  bank_mux i_bank_mux (
    .clk,
    .rd(mux_rd), .wr(mux_wr), .ev(mux_ev),
    .rd_bank(mux_rd_bank), .wr_bank(mux_wr_bank), .ev_bank(mux_ev_bank),
    .rd_row(mux_rd_row), .wr_row(mux_wr_row), .ev_row(mux_ev_row),
    .wr_data(mux_wr_data), .ev_data(mux_ev_data),
    .banks, .bank_dout
  );

  for (genvar b = 0; b < `MEM_NUMVBNK; b++) begin : g_bank
    bank_array i_bank_array (.clk, .rst, .bnk(banks[b]));
  end

endmodule

// File: test/tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk; // 4 ns period.
  end

  initial begin
    rst = 1'b1;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0; // released just after the third edge.
  end

endmodule

// File: test/mrw_mem_checker.sv
`timescale 1ns/1ns
`include "mem_params.svh"

module mrw_mem_checker (
  input logic                clk,
  input logic                rst,
  input logic                rd,
  input logic                rvalid,
  input logic                mux_rd,
  input logic                mux_wr,
  input logic                mux_ev,
  input bank_pkg::bank_idx_t mux_rd_bank,
  input bank_pkg::bank_idx_t mux_wr_bank,
  input bank_pkg::bank_idx_t mux_ev_bank
);

  // rvalid is the read strobe delayed by the bank latency.
  assert property (@(posedge clk) disable iff (rst) rvalid == $past(rd, `MEM_BANK_DELAY))
    else $error("rvalid does not follow rd by the bank latency");

  assert property (@(posedge clk) disable iff (rst)
    mux_rd && mux_wr |-> mux_rd_bank != mux_wr_bank)
    else $error("a bank got a read and a direct write in one cycle");

  // the evicted word must go to an idle bank.
  assert property (@(posedge clk) disable iff (rst)
    mux_rd && mux_ev |-> mux_ev_bank != mux_rd_bank)
    else $error("eviction aimed at the bank being read");

endmodule

bind mrw_mem_top mrw_mem_checker i_mrw_mem_checker (
  .clk, .rst, .rd, .rvalid, .mux_rd, .mux_wr, .mux_ev,
  .mux_rd_bank, .mux_wr_bank, .mux_ev_bank
);

// File: test/mrw_mem_tb.sv
`timescale 1ns/1ns
`include "mem_params.svh"

module mrw_mem_tb;
  import bank_pkg::*;

  localparam int RAND_CYCLES = 200;

  typedef struct packed {
    logic      rd;
    bank_idx_t rd_bank;
    row_t      rd_row;
    logic      wr;
    bank_idx_t wr_bank;
    row_t      wr_row;
    word_t     wr_data;
    word_t     exp_data; // read result, for table rows.
  } op_t;

  logic      clk;
  logic      rst;
  logic      rd;
  logic      wr;
  bank_idx_t rd_bank;
  bank_idx_t wr_bank;
  row_t      rd_row;
  row_t      wr_row;
  word_t     wr_data;
  word_t     rdata;
  logic      rvalid;

  op_t                      ops [$];
  word_t                    model [`MEM_NUMVBNK][`MEM_NUMVROW];
  word_t                    exp_q [$];
  logic [`MEM_BANK_DELAY-1:0] rd_hist = '0;
  int                       seed = 6647;
  int                       cycles = 0;
  int                       limit = 0;

  tb_clock i_tb_clock (.clk, .rst);

  mrw_mem_top i_mrw_mem_top (
    .clk, .rst, .rd, .wr, .rd_bank, .wr_bank, .rd_row, .wr_row, .wr_data,
    .rdata, .rvalid
  );

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("=== FAIL ===");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_word(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
      stop_run($sformatf("[ERROR] t=%0t %s: got %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      stop_run($sformatf("[ERROR] t=%0t %s: got %b, expected %b", $time, what, got, exp));
    end
  endtask

  task automatic add_op(input logic r, input int rb, input int rr, input logic w,
                        input int wb, input int wrow, input word_t d, input word_t e);
    op_t op;
    op.rd       = r;
    op.rd_bank  = bank_idx_t'(rb);
    op.rd_row   = row_t'(rr);
    op.wr       = w;
    op.wr_bank  = bank_idx_t'(wb);
    op.wr_row   = row_t'(wrow);
    op.wr_data  = d;
    op.exp_data = e;
    ops.push_back(op);
  endtask

  task automatic build_table();
    add_op(1'b1, 0, 0, 1'b0, 0, 0, '0, '0); // unwritten rows read 0.
    add_op(1'b1, 3, 15, 1'b0, 0, 0, '0, '0);
    add_op(1'b0, 0, 0, 1'b0, 0, 0, '0, '0);
    add_op(1'b1, 2, 5, 1'b1, 1, 2, 32'ha1a1_0001, '0); // different banks.
    add_op(1'b1, 1, 2, 1'b0, 0, 0, '0, 32'ha1a1_0001);
    add_op(1'b1, 0, 3, 1'b1, 0, 7, 32'hb0b0_0007, '0); // conflict, into the stash.
    add_op(1'b1, 0, 7, 1'b0, 0, 0, '0, 32'hb0b0_0007);
    add_op(1'b1, 2, 1, 1'b1, 2, 7, 32'hc2c2_0007, '0); // evicts bank 0 row 7.
    add_op(1'b1, 0, 7, 1'b0, 0, 0, '0, 32'hb0b0_0007);
    add_op(1'b1, 2, 7, 1'b0, 0, 0, '0, 32'hc2c2_0007);
    add_op(1'b1, 3, 4, 1'b1, 3, 4, 32'hd3d3_0004, '0); // same address, old value.
    add_op(1'b1, 3, 4, 1'b0, 0, 0, '0, 32'hd3d3_0004);
    add_op(1'b0, 0, 0, 1'b1, 1, 9, 32'he1e1_0009, '0);
    add_op(1'b1, 1, 9, 1'b1, 1, 9, 32'he2e2_0009, 32'he1e1_0009);
    add_op(1'b1, 1, 9, 1'b0, 0, 0, '0, 32'he2e2_0009);
    add_op(1'b1, 0, 0, 1'b1, 1, 9, 32'he3e3_0009, '0); // drops the stash copy.
    add_op(1'b1, 1, 9, 1'b0, 0, 0, '0, 32'he3e3_0009);
    add_op(1'b1, 0, 7, 1'b1, 3, 7, 32'hf3f3_0007, 32'hb0b0_0007);
    add_op(1'b1, 3, 7, 1'b1, 0, 7, 32'hf0f0_0007, 32'hf3f3_0007);
    add_op(1'b1, 0, 7, 1'b0, 0, 0, '0, 32'hf0f0_0007);
    add_op(1'b1, 2, 7, 1'b0, 0, 0, '0, 32'hc2c2_0007);
    add_op(1'b0, 0, 0, 1'b0, 0, 0, '0, '0);
  endtask

  // small row range so that the stash sees plenty of reuse.
  task automatic make_random_op(output op_t op);
    op.rd       = ($random(seed) & 3) != 0;
    op.rd_bank  = bank_idx_t'($random(seed));
    op.rd_row   = row_t'($random(seed) & 7);
    op.wr       = ($random(seed) & 3) != 0;
    op.wr_bank  = bank_idx_t'($random(seed));
    op.wr_row   = row_t'($random(seed) & 7);
    op.wr_data  = word_t'($random(seed));
    op.exp_data = '0;
  endtask

  task automatic apply_op(input op_t op, input logic use_model);
    @(posedge clk);
    #1;
    rd      = op.rd;
    rd_bank = op.rd_bank;
    rd_row  = op.rd_row;
    wr      = op.wr;
    wr_bank = op.wr_bank;
    wr_row  = op.wr_row;
    wr_data = op.wr_data;
    if (op.rd) begin
      if (use_model) begin
        exp_q.push_back(model[op.rd_bank][op.rd_row]); // read before the write lands.
      end else begin
        exp_q.push_back(op.exp_data);
      end
    end
    if (op.wr) begin
      model[op.wr_bank][op.wr_row] = op.wr_data;
    end
  endtask

  initial begin
    op_t op;
    rd      = 1'b0;
    wr      = 1'b0;
    rd_bank = '0;
    wr_bank = '0;
    rd_row  = '0;
    wr_row  = '0;
    wr_data = '0;
    for (int b = 0; b < `MEM_NUMVBNK; b++) begin
      for (int r = 0; r < `MEM_NUMVROW; r++) begin
        model[b][r] = '0;
      end
    end
    build_table();
    limit = ops.size() + RAND_CYCLES + 20;
    @(negedge rst);
    foreach (ops[i]) begin
      apply_op(ops[i], 1'b0);
    end
    repeat (RAND_CYCLES) begin
      make_random_op(op);
      apply_op(op, 1'b1);
    end
    op = '0;
    repeat (`MEM_BANK_DELAY + 1) apply_op(op, 1'b1); // drain reads in flight.
    if (exp_q.size() != 0) begin
      stop_run($sformatf("%0d reads never returned rvalid", exp_q.size()));
    end else begin
      $display("=== PASS ===");
      $finish;
    end
  end

  // outputs are registered, so mid cycle they are settled.
  always @(negedge clk) begin
    if (!rst) begin
      check_flag(rvalid, rd_hist[`MEM_BANK_DELAY-1], "rvalid");
      if (rvalid) begin
        check_word(rdata, exp_q.pop_front(), "rdata");
      end
      rd_hist = {rd_hist[`MEM_BANK_DELAY-2:0], rd};
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > limit) begin
      stop_run($sformatf("timeout: run still going after %0d cycles", limit));
    end
  end

endmodule

// File: mrw_mem_top.f
+incdir+src
src/bank_pkg.sv
src/port_pkg.sv
src/bank_if.sv
src/bank_array.sv
src/bank_mux.sv
src/stash_ram.sv
src/stash_ctrl.sv
src/mrw_mem_top.sv
test/tb_clock.sv
test/mrw_mem_checker.sv
test/mrw_mem_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := mrw_mem_tb
FILELIST  := mrw_mem_top.f
OBJ_DIR   := obj_dir
PASS_MSG  := === PASS ===

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
